// File: include/icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// Cache geometry
`define ICACHE_N_WAY        2
`define ICACHE_N_SETS       16
`define ICACHE_LINE_WIDTH   128

// Physical address split into tag, index and offset
`define ICACHE_PADDR_WIDTH  32
`define ICACHE_OFFSET_WIDTH 4
`define ICACHE_IDX_WIDTH    4
`define ICACHE_TAG_WIDTH    24

`endif

// File: verilog/icache_pkg.sv
`default_nettype none

`include "icache_config.svh"

package icache_pkg;

    // Address fields as seen by the arrays
    typedef logic [`ICACHE_IDX_WIDTH-1:0]  icache_idx_t;
    typedef logic [`ICACHE_TAG_WIDTH-1:0]  icache_tag_t;

    typedef logic [`ICACHE_LINE_WIDTH-1:0] icache_line_t;   // Whole line, four words

    // Controller states
    typedef enum logic [2:0] {
        IDLE,       // Ready for a new fetch
        LOOKUP,     // Arrays read, tag compare
        MISS_REQ,   // Fill request on the bus
        MISS_WAIT,  // Fill accepted, waiting for data
        KILLED,     // Miss killed, draining the fill
        FLUSH       // Walking the sets, valid bits cleared
    } ctrl_state_t;

    // Read result of one way for the addressed set
    typedef struct packed {
        logic         valid;
        icache_tag_t  tag;
        icache_line_t line;
    } way_rd_t;

endpackage

`default_nettype wire

// File: verilog/icache_if_pkg.sv
`default_nettype none

`include "icache_config.svh"

package icache_if_pkg;

    //----------------------------------------------------------------------
    // Core side

    typedef struct packed {
        logic                           valid;
        logic [`ICACHE_PADDR_WIDTH-1:0] paddr;   // Physical fetch address
    } ireq_t;

    typedef struct packed {
        logic                           valid;   // One cycle, no ready
        logic [`ICACHE_PADDR_WIDTH-1:0] paddr;
        logic [`ICACHE_LINE_WIDTH-1:0]  data;    // Full line holding paddr
    } iresp_t;

    //----------------------------------------------------------------------
    // Next memory level

    typedef struct packed {
        logic                           valid;   // Held until ready
        logic [`ICACHE_PADDR_WIDTH-1:0] paddr;   // Line aligned
    } fill_req_t;

    // Single beat, always accepted
    typedef struct packed {
        logic                           valid;
        logic [`ICACHE_LINE_WIDTH-1:0]  data;
    } fill_resp_t;

endpackage

`default_nettype wire

// File: verilog/icache_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

`include "icache_config.svh"

module icache_ctrl import icache_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        flush_i,
    input  logic        kill_i,
    input  logic        ireq_valid_i,
    input  logic        hit_i,          // From checker, valid in LOOKUP
    input  logic        fill_ready_i,
    input  logic        fill_valid_i,   // Fill response arrives
    output logic        ireq_ready_o,
    output logic        iresp_valid_o,
    output logic        rd_en_o,
    output logic        wr_en_o,
    output logic        flush_en_o,
    output icache_idx_t flush_idx_o,
    output logic        fill_valid_o,
    output logic        miss_o
);

    ctrl_state_t state_q, state_d;
    icache_idx_t flush_cnt_q;
    logic        fill_sent_q;   // Fill request accepted, response pending
    logic        flush_pend_q;  // Flush seen while busy
    logic        miss_q;
    logic        flush_last;

    assign ireq_ready_o = (state_q == IDLE) && !flush_i && !flush_pend_q;
    assign rd_en_o      = ireq_valid_i && ireq_ready_o;   // Arrays read at accept edge
    assign flush_en_o   = (state_q == FLUSH);
    assign flush_idx_o  = flush_cnt_q;
    assign miss_o       = miss_q;
    assign flush_last   = (flush_cnt_q == icache_idx_t'(`ICACHE_N_SETS - 1));

    always_comb begin
        state_d       = state_q;
        iresp_valid_o = 1'b0;
        wr_en_o       = 1'b0;
        fill_valid_o  = 1'b0;
        case (state_q)
            IDLE: begin
                if (flush_i || flush_pend_q) state_d = FLUSH;
                else if (rd_en_o)            state_d = LOOKUP;
            end
            LOOKUP: begin
                if (hit_i) begin
                    iresp_valid_o = !kill_i;
                    state_d       = IDLE;
                end else if (kill_i) begin
                    state_d = IDLE;               // Nothing sent yet
                end else begin
                    state_d = MISS_REQ;
                end
            end
            MISS_REQ: begin
                fill_valid_o = 1'b1;
                if (kill_i)            state_d = KILLED;
                else if (fill_ready_i) state_d = MISS_WAIT;
            end
            MISS_WAIT: begin
                if (fill_valid_i) begin
                    iresp_valid_o = !kill_i;      // Fill data passed through
                    wr_en_o       = !kill_i;
                    state_d       = IDLE;
                end else if (kill_i) begin
                    state_d = KILLED;
                end
            end
            KILLED: begin
                fill_valid_o = !fill_sent_q;      // Request still owed to the bus
                if (fill_valid_i) state_d = IDLE;
            end
            FLUSH: begin
                if (flush_last) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    // Reset starts a flush walk to clear the valid bits
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q      <= FLUSH;
            flush_cnt_q  <= '0;
            fill_sent_q  <= 1'b0;
            flush_pend_q <= 1'b0;
            miss_q       <= 1'b0;
        end else begin
            state_q     <= state_d;
            flush_cnt_q <= (state_q == FLUSH) ? flush_cnt_q + 1'b1 : '0;
            if (fill_valid_o && fill_ready_i) fill_sent_q <= 1'b1;
            else if (fill_valid_i)            fill_sent_q <= 1'b0;
            if (flush_i && state_q != IDLE && state_q != FLUSH) flush_pend_q <= 1'b1;
            else if (state_q == FLUSH)                          flush_pend_q <= 1'b0;
            miss_q <= (state_q == LOOKUP) && !hit_i && !kill_i;   // First MISS_REQ cycle
        end
    end

    //----------------------------------------------------------------------
    // Assertions

    a_fill_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        fill_valid_o && !fill_ready_i |=> fill_valid_o);

    // A write needs an accepted fill and no kill since
    a_no_wr_killed: assert property (@(posedge clk_i) disable iff (rst_i)
        wr_en_o |-> fill_sent_q && !$past(kill_i));

endmodule

`default_nettype wire

// File: verilog/icache_memory.sv
`default_nettype none
`timescale 1ns/10ps

`include "icache_config.svh"

module icache_memory import icache_pkg::*; (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  icache_idx_t                      addr_i,
    input  logic    [`ICACHE_N_WAY-1:0]      req_i,        // Read per way
    input  logic    [`ICACHE_N_WAY-1:0]      we_i,         // Write per way
    input  logic                             valid_bit_i,
    input  icache_tag_t                      tag_i,
    input  icache_line_t                     line_i,
    output way_rd_t [`ICACHE_N_WAY-1:0]      way_o
);

    // Arrays, indexed [way][set]
    logic         valid_mem [`ICACHE_N_WAY][`ICACHE_N_SETS];
    icache_tag_t  tag_mem   [`ICACHE_N_WAY][`ICACHE_N_SETS];
    icache_line_t line_mem  [`ICACHE_N_WAY][`ICACHE_N_SETS];

    always_ff @(posedge clk_i) begin
        for (int w = 0; w < `ICACHE_N_WAY; w++) begin
            if (we_i[w]) begin
                valid_mem[w][addr_i] <= valid_bit_i;
                if (valid_bit_i) begin                  // Flush only clears valid
                    tag_mem[w][addr_i]  <= tag_i;
                    line_mem[w][addr_i] <= line_i;
                end
            end
            if (req_i[w]) begin
                way_o[w].valid <= valid_mem[w][addr_i];
                way_o[w].tag   <= tag_mem[w][addr_i];
                way_o[w].line  <= line_mem[w][addr_i];
            end
        end
    end

    // Several ways written at once only when clearing valid bits
    a_one_way_write: assert property (@(posedge clk_i) disable iff (rst_i)
        !$onehot0(we_i) |-> !valid_bit_i);

endmodule

`default_nettype wire

// File: verilog/icache_replace_unit.sv
`default_nettype none
`timescale 1ns/10ps

`include "icache_config.svh"

module icache_replace_unit import icache_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  icache_idx_t                 idx_i,
    input  icache_idx_t                 flush_idx_i,
    input  logic                        rd_en_i,
    input  logic                        wr_en_i,
    input  logic                        flush_en_i,
    input  logic [`ICACHE_N_WAY-1:0]    hit_way_i,
    output icache_idx_t                 addr_o,
    output logic [`ICACHE_N_WAY-1:0]    req_o,
    output logic [`ICACHE_N_WAY-1:0]    we_o,
    output logic                        valid_bit_o
);

    localparam int WAY_BITS = $clog2(`ICACHE_N_WAY);

    logic [WAY_BITS-1:0] lru_q [`ICACHE_N_SETS];   // Way to replace next
    logic [WAY_BITS-1:0] victim;
    logic [WAY_BITS-1:0] hit_idx;
    logic                cmp_en_q;                 // Hit vector is live

    always_comb begin
        hit_idx = '0;
        for (int w = 0; w < `ICACHE_N_WAY; w++) begin
            if (hit_way_i[w]) hit_idx = WAY_BITS'(w);
        end
    end

    assign victim      = lru_q[idx_i];
    assign addr_o      = flush_en_i ? flush_idx_i : idx_i;
    assign req_o       = {`ICACHE_N_WAY{rd_en_i}};
    assign valid_bit_o = !flush_en_i;

    always_comb begin
        we_o = '0;
        if (flush_en_i)   we_o = {`ICACHE_N_WAY{1'b1}};   // Clear every way
        else if (wr_en_i) we_o[victim] = 1'b1;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) cmp_en_q <= 1'b0;
        else       cmp_en_q <= rd_en_i;
    end

    // Flush points at way 0, so fills take the empty way first
    always_ff @(posedge clk_i) begin
        if (flush_en_i)                    lru_q[flush_idx_i] <= '0;
        else if (wr_en_i)                  lru_q[idx_i] <= ~victim;
        else if (cmp_en_q && |hit_way_i)   lru_q[idx_i] <= ~hit_idx;
    end

endmodule

`default_nettype wire

// File: verilog/icache_checker.sv
`default_nettype none
`timescale 1ns/10ps

`include "icache_config.svh"

module icache_checker import icache_pkg::*; (
    input  way_rd_t [`ICACHE_N_WAY-1:0] way_i,
    input  icache_tag_t                 tag_i,
    input  logic                        fill_i,        // Fill being taken this cycle
    input  icache_line_t                fill_data_i,
    output logic    [`ICACHE_N_WAY-1:0] hit_way_o,
    output logic                        hit_o,
    output icache_line_t                data_o
);

    always_comb begin
        for (int w = 0; w < `ICACHE_N_WAY; w++) begin
            hit_way_o[w] = way_i[w].valid && (way_i[w].tag == tag_i);
        end
    end

    assign hit_o = |hit_way_o;

    // Fill data has priority over the stale way contents
    always_comb begin
        data_o = '0;
        if (fill_i) begin
            data_o = fill_data_i;
        end else begin
            for (int w = 0; w < `ICACHE_N_WAY; w++) begin
                if (hit_way_o[w]) data_o = way_i[w].line;
            end
        end
    end

    // A line lives in one way only
    always_comb begin
        a_hit_onehot: assert ($onehot0(hit_way_o))
            else $error("icache_checker: tag hit in more than one way");
    end

endmodule

`default_nettype wire

// File: verilog/top_icache.sv
`default_nettype none
`timescale 1ns/10ps

`include "icache_config.svh"

module top_icache import icache_pkg::*, icache_if_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       flush_i,
    input  logic       kill_i,
    // Core interface
    input  ireq_t      ireq_i,
    output logic       ireq_ready_o,
    output iresp_t     iresp_o,
    // Fill interface
    output fill_req_t  fill_req_o,
    input  logic       fill_ready_i,
    input  fill_resp_t fill_resp_i,
    // Perf
    output logic       miss_o
);

    logic [`ICACHE_PADDR_WIDTH-1:0] paddr_q;   // Address of the request in flight
    icache_idx_t                    req_idx;
    icache_tag_t                    req_tag;

    logic                           rd_en;
    logic                           wr_en;
    logic                           flush_en;
    icache_idx_t                    flush_idx;
    logic                           resp_valid;
    logic                           fill_valid;
    logic                           hit;
    logic    [`ICACHE_N_WAY-1:0]    hit_way;
    icache_idx_t                    arr_addr;
    logic    [`ICACHE_N_WAY-1:0]    arr_req;
    logic    [`ICACHE_N_WAY-1:0]    arr_we;
    logic                           valid_bit;
    way_rd_t [`ICACHE_N_WAY-1:0]    way_rd;
    icache_line_t                   rsp_data;

    always_ff @(posedge clk_i) begin
        if (rd_en) paddr_q <= ireq_i.paddr;
    end

    // Index bypasses the register in the accept cycle
    assign req_idx = rd_en ? ireq_i.paddr[`ICACHE_OFFSET_WIDTH +: `ICACHE_IDX_WIDTH]
                           : paddr_q[`ICACHE_OFFSET_WIDTH +: `ICACHE_IDX_WIDTH];
    assign req_tag = paddr_q[`ICACHE_PADDR_WIDTH-1 -: `ICACHE_TAG_WIDTH];

    //----------------------------------------------------------------------
    // Outputs

    assign iresp_o.valid    = resp_valid;
    assign iresp_o.paddr    = paddr_q;
    assign iresp_o.data     = rsp_data;
    assign fill_req_o.valid = fill_valid;
    assign fill_req_o.paddr = {paddr_q[`ICACHE_PADDR_WIDTH-1:`ICACHE_OFFSET_WIDTH],
                               {`ICACHE_OFFSET_WIDTH{1'b0}}};

    //----------------------------------------------------------------------
    // Blocks

    icache_ctrl i_icache_ctrl (
        .clk_i         ( clk_i             ),
        .rst_i         ( rst_i             ),
        .flush_i       ( flush_i           ),
        .kill_i        ( kill_i            ),
        .ireq_valid_i  ( ireq_i.valid      ),
        .hit_i         ( hit               ),
        .fill_ready_i  ( fill_ready_i      ),
        .fill_valid_i  ( fill_resp_i.valid ),
        .ireq_ready_o  ( ireq_ready_o      ),
        .iresp_valid_o ( resp_valid        ),
        .rd_en_o       ( rd_en             ),
        .wr_en_o       ( wr_en             ),
        .flush_en_o    ( flush_en          ),
        .flush_idx_o   ( flush_idx         ),
        .fill_valid_o  ( fill_valid        ),
        .miss_o        ( miss_o            )
    );

    icache_replace_unit i_icache_replace_unit (
        .clk_i       ( clk_i     ),
        .rst_i       ( rst_i     ),
        .idx_i       ( req_idx   ),
        .flush_idx_i ( flush_idx ),
        .rd_en_i     ( rd_en     ),
        .wr_en_i     ( wr_en     ),
        .flush_en_i  ( flush_en  ),
        .hit_way_i   ( hit_way   ),
        .addr_o      ( arr_addr  ),
        .req_o       ( arr_req   ),
        .we_o        ( arr_we    ),
        .valid_bit_o ( valid_bit )
    );

    icache_memory i_icache_memory (
        .clk_i       ( clk_i            ),
        .rst_i       ( rst_i            ),
        .addr_i      ( arr_addr         ),
        .req_i       ( arr_req          ),
        .we_i        ( arr_we           ),
        .valid_bit_i ( valid_bit        ),
        .tag_i       ( req_tag          ),
        .line_i      ( fill_resp_i.data ),
        .way_o       ( way_rd           )
    );

    icache_checker i_icache_checker (
        .way_i       ( way_rd           ),
        .tag_i       ( req_tag          ),
        .fill_i      ( wr_en            ),   // Only a kept fill reaches the core
        .fill_data_i ( fill_resp_i.data ),
        .hit_way_o   ( hit_way          ),
        .hit_o       ( hit              ),
        .data_o      ( rsp_data         )
    );

endmodule

`default_nettype wire

// File: sim/icache_monitor.sv
`default_nettype none
`timescale 1ns/10ps

`include "icache_config.svh"

module icache_monitor import icache_if_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       flush_i,
    input  logic       kill_i,
    input  ireq_t      ireq_i,
    input  logic       ireq_ready_i,
    input  iresp_t     iresp_i,
    input  fill_req_t  fill_req_i,
    input  logic       fill_ready_i,
    input  fill_resp_t fill_resp_i,
    input  logic       miss_i,
    input  logic       exp_hit_i,       // Expected lookup result of the next request
    output int         mismatch_cnt_o,
    output int         error_cnt_o
);

    logic                           txn_open;
    logic                           txn_hit;
    logic                           txn_killed;
    logic                           txn_resp;
    logic [`ICACHE_PADDR_WIDTH-1:0] txn_paddr;
    int                             age;        // Cycles since accept
    int                             fills;
    int                             misses;
    logic                           flushing;
    int                             flush_len;
    logic                           prev_stall;
    fill_req_t                      prev_req;

    // Memory model line with each word the line address plus its number
    function automatic logic [`ICACHE_LINE_WIDTH-1:0] expected_line(input logic [31:0] paddr);
        logic [31:0]                   base;
        logic [`ICACHE_LINE_WIDTH-1:0] line;
        base = {paddr[31:4], 4'h0};
        for (int w = 0; w < 4; w++) begin
            line[32*w +: 32] = base + 32'(w);
        end
        return line;
    endfunction

    task automatic report_mismatch(input string sig, input logic [127:0] got,
                                   input logic [127:0] exp);
        $display("Mismatch at %0t: %s got %0h expected %0h", $time, sig, got, exp);
        mismatch_cnt_o++;
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        error_cnt_o++;
    endtask

    always @(posedge clk_i) begin
        if (rst_i) begin
            txn_open       = 1'b0;
            flushing       = 1'b0;
            prev_stall     = 1'b0;
            mismatch_cnt_o = 0;
            error_cnt_o    = 0;
        end else begin
            //------------------------------------------------------------------
            // Flush walk length, one cycle per set
            if (flushing) begin
                if (!ireq_ready_i) begin
                    flush_len++;
                end else begin
                    if (flush_len != `ICACHE_N_SETS)
                        report_mismatch("flush_cycles", 128'(flush_len), `ICACHE_N_SETS);
                    flushing = 1'b0;
                end
            end
            if (flush_i) begin
                flushing  = 1'b1;
                flush_len = 0;
            end

            // Stalled fill request must hold
            if (prev_stall && fill_req_i !== prev_req)
                report_mismatch("fill_req_o", 128'(fill_req_i), 128'(prev_req));
            prev_stall = fill_req_i.valid && !fill_ready_i;
            prev_req   = fill_req_i;

            //------------------------------------------------------------------
            // Transaction in flight
            if (txn_open) begin
                age++;
                if (kill_i) txn_killed = 1'b1;
                if (miss_i) misses++;
                if (fill_req_i.valid && fill_ready_i) begin
                    fills++;
                    if (fill_req_i.paddr !== {txn_paddr[31:4], 4'h0})
                        report_mismatch("fill_req_o.paddr", 128'(fill_req_i.paddr),
                                        128'({txn_paddr[31:4], 4'h0}));
                end
                if (iresp_i.valid) begin
                    if (txn_killed) begin
                        report_error($sformatf("response after a kill for %h", txn_paddr));
                    end else if (txn_resp) begin
                        report_error($sformatf("second response for %h", txn_paddr));
                    end else begin
                        txn_resp = 1'b1;
                        if (iresp_i.data !== expected_line(txn_paddr))
                            report_mismatch("iresp_o.data", iresp_i.data,
                                            expected_line(txn_paddr));
                        if (iresp_i.paddr !== txn_paddr)
                            report_mismatch("iresp_o.paddr", 128'(iresp_i.paddr),
                                            128'(txn_paddr));
                        if (txn_hit && age != 1)
                            report_mismatch("resp_cycle", 128'(age), 128'(1));
                        if (!txn_hit && !fill_resp_i.valid)
                            report_error($sformatf("miss response for %h not in the fill cycle",
                                                   txn_paddr));
                    end
                end
                if (ireq_ready_i) begin              // Back in IDLE
                    if (!txn_killed && !txn_resp)
                        report_error($sformatf("no response for read of %h", txn_paddr));
                    if (fills != (txn_hit ? 0 : 1))
                        report_mismatch("fill_count", 128'(fills), txn_hit ? 0 : 1);
                    if (misses != (txn_hit ? 0 : 1))
                        report_mismatch("miss_count", 128'(misses), txn_hit ? 0 : 1);
                    txn_open = 1'b0;
                end
            end else if (iresp_i.valid || fill_req_i.valid || miss_i) begin
                report_error("cache activity with no request in flight");
            end

            if (ireq_i.valid && ireq_ready_i) begin
                txn_open   = 1'b1;
                txn_hit    = exp_hit_i;
                txn_killed = 1'b0;
                txn_resp   = 1'b0;
                txn_paddr  = ireq_i.paddr;
                age        = 0;
                fills      = 0;
                misses     = 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_top_icache.sv
`default_nettype none
`timescale 1ns/10ps

`include "icache_config.svh"

module tb_top_icache import icache_if_pkg::*; ();

    localparam int TIMEOUT = 200;   // Cycles per wait
    localparam int N_STEPS = 21;

    typedef enum logic [1:0] {OP_READ, OP_KILL, OP_FLUSH} op_t;

    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        logic        hit;     // Expected lookup result
        logic        stall;   // Random fill_ready_i stalls
    } step_t;

    logic       clk;
    logic       rst;
    logic       flush;
    logic       kill;
    logic       fill_ready;
    logic       ireq_ready;
    logic       miss;
    ireq_t      ireq;
    iresp_t     iresp;
    fill_req_t  fill_req;
    fill_resp_t fill_resp;
    logic       exp_hit;
    logic       stall_en;
    logic       timed_out;
    int         mismatches;
    int         errors;
    step_t      steps [N_STEPS];

    top_icache i_top_icache (
        .clk_i        ( clk        ),
        .rst_i        ( rst        ),
        .flush_i      ( flush      ),
        .kill_i       ( kill       ),
        .ireq_i       ( ireq       ),
        .ireq_ready_o ( ireq_ready ),
        .iresp_o      ( iresp      ),
        .fill_req_o   ( fill_req   ),
        .fill_ready_i ( fill_ready ),
        .fill_resp_i  ( fill_resp  ),
        .miss_o       ( miss       )
    );

    icache_monitor i_icache_monitor (
        .clk_i          ( clk        ),
        .rst_i          ( rst        ),
        .flush_i        ( flush      ),
        .kill_i         ( kill       ),
        .ireq_i         ( ireq       ),
        .ireq_ready_i   ( ireq_ready ),
        .iresp_i        ( iresp      ),
        .fill_req_i     ( fill_req   ),
        .fill_ready_i   ( fill_ready ),
        .fill_resp_i    ( fill_resp  ),
        .miss_i         ( miss       ),
        .exp_hit_i      ( exp_hit    ),
        .mismatch_cnt_o ( mismatches ),
        .error_cnt_o    ( errors     )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //----------------------------------------------------------------------
    // Next level memory

    function automatic logic [`ICACHE_LINE_WIDTH-1:0] model_line(input logic [31:0] paddr);
        logic [31:0]                   base;
        logic [`ICACHE_LINE_WIDTH-1:0] line;
        base = {paddr[31:4], 4'h0};
        for (int w = 0; w < 4; w++) begin
            line[32*w +: 32] = base + 32'(w);
        end
        return line;
    endfunction

    initial begin
        logic stalling;
        fill_ready = 1'b1;
        forever begin
            @(posedge clk);
            stalling = stall_en;
            @(negedge clk);
            fill_ready = !stalling || ($urandom_range(0, 2) != 0);
        end
    end

    initial begin
        logic [31:0] fill_addr;
        int          delay;
        fill_resp = '0;
        forever begin
            @(posedge clk);
            if (!rst && fill_req.valid && fill_ready) begin
                fill_addr = fill_req.paddr;
                delay     = int'($urandom_range(1, 6));
                repeat (delay) @(negedge clk);
                fill_resp.valid = 1'b1;
                fill_resp.data  = model_line(fill_addr);
                @(negedge clk);
                fill_resp = '0;   // Single beat
            end
        end
    end

    //----------------------------------------------------------------------
    // Stimulus

    task automatic wait_ready(input string what);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!ireq_ready && n < TIMEOUT);
        if (!ireq_ready) begin
            $display("Timeout: ireq_ready_o stayed low %s", what);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_read(input logic [31:0] addr, input logic with_kill);
        int n;
        ireq.valid = 1'b1;
        ireq.paddr = addr;
        wait_ready("with a request waiting");
        if (timed_out) return;
        @(negedge clk);
        ireq = '0;
        if (with_kill) begin
            n = 0;
            do begin
                @(negedge clk);   // Request is a registered output here
                n++;
            end while (!fill_req.valid && n < TIMEOUT);
            if (!fill_req.valid) begin
                $display("Timeout: no fill request for killed read of %h", addr);
                timed_out = 1'b1;
                return;
            end
            kill = 1'b1;
            @(negedge clk);
            kill = 1'b0;
        end
        wait_ready("after a read");
    endtask

    task automatic run_flush();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        wait_ready("during a flush");
    endtask

    initial begin
        void'($urandom(55380));
        rst       = 1'b1;
        flush     = 1'b0;
        kill      = 1'b0;
        ireq      = '0;
        exp_hit   = 1'b0;
        stall_en  = 1'b0;
        timed_out = 1'b0;
        // A, A+4, B and C share set 4; E, F and G share set 9
        steps = '{
            '{OP_READ,  32'h0000_1040, 1'b0, 1'b0},   // Cold miss
            '{OP_READ,  32'h0000_1044, 1'b1, 1'b0},
            '{OP_READ,  32'h0000_2040, 1'b0, 1'b0},
            '{OP_READ,  32'h0000_1040, 1'b1, 1'b0},
            '{OP_READ,  32'h0000_3048, 1'b0, 1'b0},   // Evicts B
            '{OP_READ,  32'h0000_1040, 1'b1, 1'b0},
            '{OP_READ,  32'h0000_2040, 1'b0, 1'b0},
            '{OP_KILL,  32'h0000_5070, 1'b0, 1'b0},
            '{OP_READ,  32'h0000_5070, 1'b0, 1'b0},   // Killed fill not kept
            '{OP_READ,  32'h0000_5070, 1'b1, 1'b0},
            '{OP_FLUSH, 32'h0000_0000, 1'b0, 1'b0},
            '{OP_READ,  32'h0000_5070, 1'b0, 1'b0},
            '{OP_READ,  32'h0001_0090, 1'b0, 1'b1},
            '{OP_READ,  32'h0001_0090, 1'b1, 1'b1},
            '{OP_READ,  32'h0002_0094, 1'b0, 1'b1},
            '{OP_READ,  32'h0001_0090, 1'b1, 1'b1},
            '{OP_READ,  32'h0003_009C, 1'b0, 1'b1},   // Evicts F
            '{OP_READ,  32'h0001_0090, 1'b1, 1'b1},
            '{OP_READ,  32'h0002_0094, 1'b0, 1'b1},
            '{OP_KILL,  32'h0003_009C, 1'b0, 1'b1},
            '{OP_READ,  32'h0003_009C, 1'b0, 1'b1}
        };
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait_ready("after reset");
        for (int i = 0; i < N_STEPS; i++) begin
            if (timed_out) break;
            @(negedge clk);
            stall_en = steps[i].stall;
            exp_hit  = steps[i].hit;
            case (steps[i].op)
                OP_FLUSH: run_flush();
                OP_KILL:  run_read(steps[i].addr, 1'b1);
                default:  run_read(steps[i].addr, 1'b0);
            endcase
        end
        @(negedge clk);   // Let the monitor close the last read
        $display("Errors: %0d mismatches, %0d other, %0d timeouts",
                 mismatches, errors, timed_out ? 1 : 0);
        if (mismatches == 0 && errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: icache.f
+incdir+include
verilog/icache_pkg.sv
verilog/icache_if_pkg.sv
verilog/icache_ctrl.sv
verilog/icache_memory.sv
verilog/icache_replace_unit.sv
verilog/icache_checker.sv
verilog/top_icache.sv
sim/icache_monitor.sv
sim/tb_top_icache.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP      = tb_top_icache
FILELIST = icache.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '=== PASS ==='

$(BIN): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

clean:
	rm -rf $(OBJ_DIR)
